/* Makefile */
# Verilator build and run for the blocking cache testbench

VERILATOR ?= verilator
TOP       ?= blocking_cache_tb
RTL_TOP   ?= blocking_cache
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Test completed successfully

SRCS     := $(shell grep -v '^+' $(FILE_LIST))
RTL_SRCS := $(filter design/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation FAILED, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/blocking_cache.sv */
//------------------------------
// Blocking cache top, control and datapath
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module blocking_cache
  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int cache_nbytes = 256,
  localparam int n_lines     = cache_nbytes * 8 / line_bits,
  localparam int idx_bits    = $clog2(n_lines)
) (
  input  logic       clk,
  input  logic       reset,

  // Processor port
  input  logic       cachereq_val,
  input  mem_req_t   cachereq_msg,
  output logic       busy,
  output logic       cacheresp_val,
  output mem_resp_t  cacheresp_msg,

  // Memory port
  output logic       memreq_val,
  output line_req_t  memreq_msg,
  input  logic       memresp_val,
  input  line_resp_t memresp_msg
);

  dpath_ctrl_t         ctrl;
  mem_type_e           cacheresp_type;
  mem_type_e           memreq_type;
  mem_type_e           req_type;
  logic                tag_match;
  logic [1:0]          word_offset;
  logic [idx_bits-1:0] req_index;

  blocking_cache_ctrl #(
    .cache_nbytes (cache_nbytes)
  ) u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .busy           (busy),
    .cacheresp_val  (cacheresp_val),
    .memreq_val     (memreq_val),
    .memresp_val    (memresp_val),
    .tag_match      (tag_match),
    .req_type       (req_type),
    .word_offset    (word_offset),
    .req_index      (req_index),
    .ctrl           (ctrl),
    .cacheresp_type (cacheresp_type),
    .memreq_type    (memreq_type)
  );

  blocking_cache_dpath #(
    .cache_nbytes (cache_nbytes)
  ) u_dpath (
    .clk            (clk),
    .reset          (reset),
    .cachereq_msg   (cachereq_msg),
    .memresp_msg    (memresp_msg),
    .ctrl           (ctrl),
    .cacheresp_type (cacheresp_type),
    .memreq_type    (memreq_type),
    .tag_match      (tag_match),
    .req_type       (req_type),
    .word_offset    (word_offset),
    .req_index      (req_index),
    .cacheresp_msg  (cacheresp_msg),
    .memreq_msg     (memreq_msg)
  );

endmodule

`default_nettype wire

/* design/blocking_cache_ctrl.sv */
//------------------------------
// Blocking cache control FSM with per-line valid
// and dirty bits
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module blocking_cache_ctrl
  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int cache_nbytes = 256,
  localparam int n_lines     = cache_nbytes * 8 / line_bits,
  localparam int idx_bits    = $clog2(n_lines)
) (
  input  logic                clk,
  input  logic                reset,

  input  logic                cachereq_val,
  output logic                busy,
  output logic                cacheresp_val,
  output logic                memreq_val,
  input  logic                memresp_val,

  input  logic                tag_match,
  input  mem_type_e           req_type,
  input  logic [1:0]          word_offset,
  input  logic [idx_bits-1:0] req_index,

  output dpath_ctrl_t         ctrl,
  output mem_type_e           cacheresp_type,
  output mem_type_e           memreq_type
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_access,
    st_respond,
    st_evict_read,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_refill_update
  } state_t;

  state_t state;
  state_t state_next;

  logic [n_lines-1:0] valid_bits;
  logic [n_lines-1:0] dirty_bits;
  logic               line_valid;
  logic               line_dirty;
  logic               hit;
  logic               write_req;
  logic               accept;

  assign line_valid = valid_bits[req_index];
  assign line_dirty = dirty_bits[req_index];
  assign hit        = tag_match && line_valid;
  assign write_req  = (req_type == mem_write);

  // Busy through the response cycle as well
  assign busy   = (state != st_idle) || cacheresp_val;
  assign accept = cachereq_val && !busy;

  //------------------------------
  // State register
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_idle;
      cacheresp_val <= 1'b0;
    end else begin
      state         <= state_next;
      cacheresp_val <= (state == st_respond);   // Read register loaded by now
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle:          if (accept) state_next = st_tag_check;
      st_tag_check: begin
        if (hit)
          state_next = st_access;
        else if (line_valid && line_dirty)
          state_next = st_evict_read;
        else
          state_next = st_refill_req;
      end
      st_access:        state_next = st_respond;
      st_respond:       state_next = st_idle;
      st_evict_read:    state_next = st_evict_req;
      st_evict_req:     state_next = st_evict_wait;
      st_evict_wait:    if (memresp_val) state_next = st_refill_req;
      st_refill_req:    state_next = st_refill_wait;
      st_refill_wait:   if (memresp_val) state_next = st_refill_update;
      st_refill_update: state_next = st_access;   // Finish as a hit
      default:          state_next = st_idle;
    endcase
  end

  //------------------------------
  // Valid and dirty bits
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (state == st_refill_update) begin
      valid_bits[req_index] <= 1'b1;
      dirty_bits[req_index] <= 1'b0;
    end else if (state == st_access && write_req) begin
      dirty_bits[req_index] <= 1'b1;
    end
  end

  //------------------------------
  // Datapath controls and strobes
  //------------------------------

  always_comb begin
    ctrl        = '0;
    memreq_val  = 1'b0;
    memreq_type = mem_read;

    ctrl.word_sel_zero = write_req;   // Write responses carry no data

    case (state)
      st_idle:       ctrl.req_en = accept;
      st_tag_check:  ctrl.tag_ren = 1'b1;
      st_access: begin
        if (write_req) begin
          ctrl.data_wen              = 1'b1;
          ctrl.word_wen[word_offset] = 1'b1;
        end
      end
      st_respond: begin
        ctrl.data_ren     = 1'b1;
        ctrl.read_data_en = 1'b1;
      end
      st_evict_read: begin
        ctrl.tag_ren       = 1'b1;          // Old tag forms the victim address
        ctrl.data_ren      = 1'b1;
        ctrl.read_data_en  = 1'b1;
        ctrl.evict_addr_en = 1'b1;
      end
      st_evict_req: begin
        memreq_val  = 1'b1;
        memreq_type = mem_write;
      end
      st_refill_req: begin
        memreq_val           = 1'b1;
        ctrl.memreq_addr_sel = 1'b1;
      end
      st_refill_wait: ctrl.memresp_en = memresp_val;
      st_refill_update: begin
        ctrl.tag_wen        = 1'b1;
        ctrl.data_wen       = 1'b1;
        ctrl.word_wen       = '1;           // Whole line from memory
        ctrl.write_data_sel = 1'b1;
      end
      default: ;
    endcase
  end

  assign cacheresp_type = req_type;

endmodule

`default_nettype wire

/* design/blocking_cache_dpath.sv */
//------------------------------
// Blocking cache datapath: request and refill registers,
// tag and data arrays, tag compare, message packing
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module blocking_cache_dpath
  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int cache_nbytes = 256,
  localparam int n_lines     = cache_nbytes * 8 / line_bits,
  localparam int idx_bits    = $clog2(n_lines),
  localparam int tag_bits    = line_num_bits - idx_bits
) (
  input  logic                clk,
  input  logic                reset,

  input  mem_req_t            cachereq_msg,
  input  line_resp_t          memresp_msg,
  input  dpath_ctrl_t         ctrl,
  input  mem_type_e           cacheresp_type,
  input  mem_type_e           memreq_type,

  output logic                tag_match,
  output mem_type_e           req_type,
  output logic [1:0]          word_offset,
  output logic [idx_bits-1:0] req_index,
  output mem_resp_t           cacheresp_msg,
  output line_req_t           memreq_msg
);

  //------------------------------
  // Request and refill registers
  //------------------------------

  cache_addr_u          req_addr;
  logic [word_bits-1:0] req_data;
  logic [line_bits-1:0] refill_line;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_type     <= mem_read;
      req_addr.raw <= '0;
      req_data     <= '0;
    end else if (ctrl.req_en) begin
      req_type     <= cachereq_msg.msg_type;
      req_addr.raw <= cachereq_msg.addr;
      req_data     <= cachereq_msg.data;
    end
    if (ctrl.memresp_en)
      refill_line <= memresp_msg.data;
  end

  logic [tag_bits-1:0] req_tag;

  assign req_index   = req_addr.fields.line_num[idx_bits-1:0];
  assign req_tag     = req_addr.fields.line_num[line_num_bits-1:idx_bits];
  assign word_offset = req_addr.fields.word_off;

  // Store word copied to every slot, word enables pick the one written
  logic [line_bits-1:0] write_line;

  assign write_line = ctrl.write_data_sel ? refill_line : {words_per_line{req_data}};

  //------------------------------
  // Tag and data arrays
  //------------------------------

  logic [tag_bits-1:0]                       tag_array [n_lines];
  logic [words_per_line-1:0][word_bits-1:0]  data_array [n_lines];
  logic [tag_bits-1:0]                       read_tag;
  logic [line_bits-1:0]                      cache_line;

  // Combinational read, zero while not enabled
  assign read_tag   = ctrl.tag_ren  ? tag_array[req_index]  : '0;
  assign cache_line = ctrl.data_ren ? data_array[req_index] : '0;

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen)
      tag_array[req_index] <= req_tag;
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < words_per_line; i++) begin
      if (ctrl.data_wen && ctrl.word_wen[i])
        data_array[req_index][i] <= write_line[i*word_bits +: word_bits];
    end
  end

  assign tag_match = (read_tag == req_tag);

  //------------------------------
  // Line addresses
  //------------------------------

  logic [addr_bits-1:0] refill_addr;
  logic [addr_bits-1:0] victim_addr;
  logic [addr_bits-1:0] evict_addr;
  logic [addr_bits-1:0] memreq_addr;

  assign refill_addr = {req_tag, req_index, 4'b0};
  assign victim_addr = {read_tag, req_index, 4'b0};   // Old line still in place

  always_ff @(posedge clk) begin
    if (ctrl.evict_addr_en)
      evict_addr <= victim_addr;
  end

  assign memreq_addr = ctrl.memreq_addr_sel ? refill_addr : evict_addr;

  //------------------------------
  // Read register and word select
  //------------------------------

  logic [words_per_line-1:0][word_bits-1:0] read_line;
  logic [word_bits-1:0]                     resp_word;

  always_ff @(posedge clk) begin
    if (ctrl.read_data_en)
      read_line <= cache_line;
  end

  assign resp_word = ctrl.word_sel_zero ? '0 : read_line[word_offset];

  // Outgoing messages, opaque and length always zero
  always_comb begin
    cacheresp_msg.msg_type = cacheresp_type;
    cacheresp_msg.opaque   = '0;
    cacheresp_msg.len      = '0;
    cacheresp_msg.data     = resp_word;
  end

  always_comb begin
    memreq_msg.msg_type = memreq_type;
    memreq_msg.opaque   = '0;
    memreq_msg.addr     = memreq_addr;
    memreq_msg.len      = '0;
    memreq_msg.data     = read_line;       // Writeback data, ignored on reads
  end

endmodule

`default_nettype wire

/* design/cache_cfg_pkg.sv */
//------------------------------
// Cache geometry constants, address decode union
// and datapath control bundle
//------------------------------
`default_nettype none

package cache_cfg_pkg;

  //------------------------------
  // Line geometry
  //------------------------------

  localparam int word_bits      = 32;
  localparam int addr_bits      = 32;
  localparam int line_bits      = 128;
  localparam int words_per_line = line_bits / word_bits;
  localparam int line_num_bits  = addr_bits - 4;   // Above word and byte offsets

  // One address word, seen raw or split into its fields
  typedef struct packed {
    logic [line_num_bits-1:0] line_num;            // Tag and index together
    logic [1:0]               word_off;
    logic [1:0]               byte_off;
  } addr_fields_t;

  typedef union packed {
    logic [addr_bits-1:0] raw;
    addr_fields_t         fields;
  } cache_addr_u;

  //------------------------------
  // Control to datapath
  //------------------------------

  typedef struct packed {
    logic                      req_en;             // Load request registers
    logic                      memresp_en;         // Load refill line
    logic                      write_data_sel;     // 1 selects refill line
    logic                      tag_ren;
    logic                      tag_wen;
    logic                      data_ren;
    logic                      data_wen;
    logic [words_per_line-1:0] word_wen;           // Per word write enable
    logic                      evict_addr_en;
    logic                      memreq_addr_sel;    // 1 selects refill address
    logic                      read_data_en;
    logic                      word_sel_zero;      // Zero data in response
  } dpath_ctrl_t;

endpackage

`default_nettype wire

/* design/mem_msg_pkg.sv */
//------------------------------
// Memory message types for the processor port
// and the line-wide memory port
//------------------------------
`default_nettype none

package mem_msg_pkg;

  import cache_cfg_pkg::*;

  typedef enum logic [2:0] {
    mem_read  = 3'd0,
    mem_write = 3'd1
  } mem_type_e;

  //------------------------------
  // Processor side, one word
  //------------------------------

  typedef struct packed {
    mem_type_e            msg_type;
    logic [7:0]           opaque;
    logic [addr_bits-1:0] addr;
    logic [1:0]           len;                     // Zero means full word
    logic [word_bits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e            msg_type;
    logic [7:0]           opaque;
    logic [1:0]           len;
    logic [word_bits-1:0] data;                    // Zero for writes
  } mem_resp_t;

  //------------------------------
  // Memory side, full line
  //------------------------------

  typedef struct packed {
    mem_type_e            msg_type;
    logic [7:0]           opaque;
    logic [addr_bits-1:0] addr;                    // Line aligned
    logic [3:0]           len;
    logic [line_bits-1:0] data;
  } line_req_t;

  typedef struct packed {
    mem_type_e            msg_type;
    logic [7:0]           opaque;
    logic [3:0]           len;
    logic [line_bits-1:0] data;
  } line_resp_t;

endpackage

`default_nettype wire

/* verification/blocking_cache_asserts.sv */
//------------------------------
// Port protocol assertions, bound to the cache top
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module blocking_cache_asserts (
  input logic clk,
  input logic reset,
  input logic cachereq_val,
  input logic busy,
  input logic cacheresp_val,
  input logic memreq_val
);

  // All quiet once reset has been seen
  idle_after_reset: assert property (
    @(posedge clk) reset |=> (!busy && !cacheresp_val && !memreq_val)
  ) else $error("busy or a strobe is high right after reset");

  resp_one_cycle: assert property (
    @(posedge clk) disable iff (reset) cacheresp_val |=> !cacheresp_val
  ) else $error("cacheresp_val held longer than one cycle");

  memreq_one_cycle: assert property (
    @(posedge clk) disable iff (reset) memreq_val |=> !memreq_val
  ) else $error("memreq_val held longer than one cycle");

  // Busy from the cycle after acceptance
  accept_sets_busy: assert property (
    @(posedge clk) disable iff (reset) (cachereq_val && !busy) |=> busy
  ) else $error("busy not raised after an accepted request");

endmodule

bind blocking_cache blocking_cache_asserts u_asserts (
  .clk           (clk),
  .reset         (reset),
  .cachereq_val  (cachereq_val),
  .busy          (busy),
  .cacheresp_val (cacheresp_val),
  .memreq_val    (memreq_val)
);

`default_nettype wire

/* verification/blocking_cache_tb.sv */
//------------------------------
// Blocking cache testbench with clock, reset, memory model,
// reference model, compare tasks and directed tests
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module blocking_cache_tb
  import cache_cfg_pkg::*;
  import mem_msg_pkg::*;
();

  localparam int          cache_nbytes   = 256;
  localparam int          mem_words_n    = 1024;
  localparam int          n_accesses     = 270;   // Directed 6, random 200, sweep 64
  localparam int          timeout_cycles = 40 * n_accesses;
  localparam logic [31:0] lcg_seed       = 32'h0a82cd32;
  localparam logic [31:0] base_addr      = 32'h0000_0124;

  logic       clk;
  logic       reset;
  logic       cachereq_val;
  mem_req_t   cachereq_msg;
  logic       busy;
  logic       cacheresp_val;
  mem_resp_t  cacheresp_msg;
  logic       memreq_val;
  line_req_t  memreq_msg;
  logic       memresp_val;
  line_resp_t memresp_msg;

  logic [31:0] mem_words [mem_words_n];   // Memory model contents
  logic [31:0] ref_mem   [mem_words_n];   // Expected value of each word
  logic [31:0] delay_rng      = lcg_seed;
  logic [31:0] stim_rng       = lcg_seed;
  int          cycle_count    = 0;
  int          read_reqs      = 0;
  int          write_reqs     = 0;
  int          req_seq        = 0;
  int          last_read_seq  = 0;
  int          last_write_seq = 0;
  line_req_t   last_read_req;
  line_req_t   last_write_req;
  logic        run_done       = 1'b0;
  logic        fail_printed   = 1'b0;

  blocking_cache #(
    .cache_nbytes (cache_nbytes)
  ) DUT (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_msg  (cachereq_msg),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_msg (cacheresp_msg),
    .memreq_val    (memreq_val),
    .memreq_msg    (memreq_msg),
    .memresp_val   (memresp_val),
    .memresp_msg   (memresp_msg)
  );

  //------------------------------
  // Helpers
  //------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word at byte address A starts as A xor a fixed pattern
  function automatic logic [31:0] init_word(input int idx);
    return 32'(idx * 4) ^ 32'h5a5a0000;
  endfunction

  function automatic logic [line_bits-1:0] ref_line(input logic [31:0] addr);
    logic [line_bits-1:0] line;
    int                   base;
    base = int'(addr[11:4]) * words_per_line;
    for (int k = 0; k < words_per_line; k++)
      line[k*word_bits +: word_bits] = ref_mem[base + k];
    return line;
  endfunction

  function automatic mem_resp_t expected_resp(input mem_type_e t, input logic [31:0] addr);
    mem_resp_t r;
    r          = '0;
    r.msg_type = t;
    if (t == mem_read)
      r.data = ref_mem[addr[11:2]];   // Writes answer with zero data
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    fail_printed = 1'b1;
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  //------------------------------
  // Compare tasks
  //------------------------------

  task automatic check_resp(input mem_resp_t got, input mem_resp_t expected, input string what);
    if (got !== expected)
      abort_run($sformatf("CHECK FAILED at %0t: %s got type %0d data %h, expected type %0d data %h",
                          $time, what, got.msg_type, got.data, expected.msg_type, expected.data));
  endtask

  task automatic check_memreq(input line_req_t got, input line_req_t expected, input string what);
    logic data_ok;
    data_ok = (expected.msg_type == mem_read) || (got.data === expected.data);  // Reads carry none
    if (got.msg_type !== expected.msg_type || got.addr !== expected.addr ||
        got.opaque !== expected.opaque || got.len !== expected.len || !data_ok)
      abort_run($sformatf("CHECK FAILED at %0t: %s got type %0d addr %h data %h, expected %0d %h %h",
                          $time, what, got.msg_type, got.addr, got.data,
                          expected.msg_type, expected.addr, expected.data));
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected)
      abort_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                          $time, what, got, expected));
  endtask

  //------------------------------
  // Access tasks
  //------------------------------

  task automatic access_and_check(input mem_type_e t, input logic [31:0] addr,
                                  input logic [31:0] data, output int lat);
    mem_req_t  req;
    mem_resp_t expected;
    req          = '0;
    req.msg_type = t;
    req.addr     = addr;
    req.data     = data;
    expected     = expected_resp(t, addr);
    @(posedge clk);
    while (busy)
      @(posedge clk);
    cachereq_val <= 1'b1;
    cachereq_msg <= req;
    @(posedge clk);                       // Accepted on this edge
    cachereq_val <= 1'b0;
    lat = 0;
    @(posedge clk);
    while (!cacheresp_val) begin
      lat++;
      @(posedge clk);
    end
    check_resp(cacheresp_msg, expected,
               $sformatf("%s response for %h", (t == mem_write) ? "write" : "read", addr));
    if (t == mem_write)
      ref_mem[addr[11:2]] = data;
  endtask

  // Hit answers 3 cycles after acceptance, no memory traffic
  task automatic hit_access(input mem_type_e t, input logic [31:0] addr, input logic [31:0] data);
    int rd0;
    int wr0;
    int lat;
    rd0 = read_reqs;
    wr0 = write_reqs;
    access_and_check(t, addr, data, lat);
    check_value(lat, 3, "hit latency");
    check_value((read_reqs - rd0) + (write_reqs - wr0), 0, "memory requests on a hit");
  endtask

  //------------------------------
  // Directed tests
  //------------------------------

  task automatic read_miss_test();
    int        rd0;
    int        wr0;
    int        lat;
    line_req_t expected;
    rd0 = read_reqs;
    wr0 = write_reqs;
    access_and_check(mem_read, base_addr, '0, lat);
    check_value(read_reqs - rd0, 1, "refill reads on clean miss");
    check_value(write_reqs - wr0, 0, "writebacks on clean miss");
    expected          = '0;
    expected.msg_type = mem_read;
    expected.addr     = {base_addr[31:4], 4'b0};
    check_memreq(last_read_req, expected, "refill request");
  endtask

  task automatic read_hit_test();
    hit_access(mem_read, base_addr, '0);
    hit_access(mem_read, base_addr + 32'd4, '0);   // Other word, same line
  endtask

  task automatic write_hit_test();
    hit_access(mem_write, base_addr + 32'd8, 32'hc0ffee01);
    hit_access(mem_read, base_addr + 32'd8, '0);
  endtask

  task automatic dirty_miss_test();
    logic [31:0] conflict_addr;
    line_req_t   wb_expected;
    line_req_t   refill_expected;
    int          rd0;
    int          wr0;
    int          lat;
    conflict_addr            = base_addr + 32'(cache_nbytes);   // Same index, new tag
    wb_expected              = '0;
    wb_expected.msg_type     = mem_write;
    wb_expected.addr         = {base_addr[31:4], 4'b0};
    wb_expected.data         = ref_line(base_addr);
    refill_expected          = '0;
    refill_expected.msg_type = mem_read;
    refill_expected.addr     = {conflict_addr[31:4], 4'b0};
    rd0 = read_reqs;
    wr0 = write_reqs;
    access_and_check(mem_read, conflict_addr, '0, lat);
    check_value(write_reqs - wr0, 1, "writebacks on dirty miss");
    check_value(read_reqs - rd0, 1, "refill reads on dirty miss");
    check_memreq(last_write_req, wb_expected, "writeback request");
    check_memreq(last_read_req, refill_expected, "refill request");
    if (last_write_seq > last_read_seq)
      abort_run("The refill read was sent before the writeback of the dirty line");
  endtask

  task automatic random_test();
    mem_type_e   t;
    logic [31:0] addr;
    logic [31:0] data;
    int          lat;
    for (int i = 0; i < 200; i++) begin
      stim_rng = lcg_next(stim_rng);
      t        = stim_rng[31] ? mem_write : mem_read;
      addr     = {22'd0, stim_rng[25:18], 2'b00};   // Anywhere in the first 1 KiB
      stim_rng = lcg_next(stim_rng);
      data     = stim_rng;
      access_and_check(t, addr, data, lat);
    end
    // Sweep all 64 lines so lines 0 to 47 end up back in memory
    for (int line = 0; line < 64; line++)
      access_and_check(mem_read, 32'(line * 16 + (line % 4) * 4), '0, lat);
    for (int i = 0; i < 192; i++)
      check_value(mem_words[i], ref_mem[i], $sformatf("memory word %0d after sweep", i));
  endtask

  //------------------------------
  // Clock, memory model, timeout
  //------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : memory_model
    line_req_t  req;
    line_resp_t resp;
    int         wait_left;
    int         base;
    logic       pending;
    memresp_val = 1'b0;
    memresp_msg = '0;
    pending     = 1'b0;
    wait_left   = 0;
    base        = 0;
    req         = '0;
    for (int i = 0; i < mem_words_n; i++)
      mem_words[i] = init_word(i);
    forever begin
      @(posedge clk);
      memresp_val <= 1'b0;
      if (pending && wait_left == 0) begin
        resp          = '0;
        resp.msg_type = req.msg_type;
        if (req.msg_type == mem_read)
          for (int k = 0; k < words_per_line; k++)
            resp.data[k*word_bits +: word_bits] = mem_words[base + k];
        memresp_val <= 1'b1;
        memresp_msg <= resp;
        pending = 1'b0;
      end else if (pending) begin
        wait_left--;
      end
      if (memreq_val && !reset) begin
        if (pending)
          abort_run("A memory request came while another one was still outstanding");
        req     = memreq_msg;
        base    = int'(req.addr[11:4]) * words_per_line;
        req_seq = req_seq + 1;
        if (req.msg_type == mem_write) begin
          for (int k = 0; k < words_per_line; k++)
            mem_words[base + k] = req.data[k*word_bits +: word_bits];
          write_reqs     = write_reqs + 1;
          last_write_req = req;
          last_write_seq = req_seq;
        end else begin
          read_reqs      = read_reqs + 1;
          last_read_req  = req;
          last_read_seq  = req_seq;
        end
        delay_rng = lcg_next(delay_rng);
        wait_left = int'(delay_rng[17:16]);        // Answer 2 to 5 cycles later
        pending   = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
      abort_run($sformatf("Timeout, the run did not finish within %0d cycles", timeout_cycles));
  end

  initial begin
    reset        = 1'b1;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    for (int i = 0; i < mem_words_n; i++)
      ref_mem[i] = init_word(i);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    read_miss_test();
    read_hit_test();
    write_hit_test();
    dirty_miss_test();
    random_test();
    run_done = 1'b1;
    $display("Test completed successfully");
    $finish;
  end

  // Run stopped by a failing assertion
  final begin
    if (!run_done && !fail_printed)
      $display("Test failed");
  end

endmodule

`default_nettype wire

/* verilog.f */
design/cache_cfg_pkg.sv
design/mem_msg_pkg.sv
design/blocking_cache_dpath.sv
design/blocking_cache_ctrl.sv
design/blocking_cache.sv
verification/blocking_cache_asserts.sv
verification/blocking_cache_tb.sv
